// File: axi_lite_pkg.sv
package axi_lite_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;  // One strobe bit per byte lane

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response codes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Only OKAY and SLVERR are ever produced by the memory
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_t;

endpackage

// File: lsu_pkg.sv
package lsu_pkg;

  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2
  } access_size_t;

  // Bit shift that moves lane 0 onto the lane picked by the byte offset
  function automatic logic [4:0] lane_shift(input logic [1:0] offset);
    return {offset, 3'b000};
  endfunction

  // Strobe pattern of an access that starts on lane 0
  function automatic logic [3:0] size_strobe(input access_size_t size);
    case (size)
      SIZE_B:  return 4'b0001;
      SIZE_H:  return 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic logic is_misaligned(input access_size_t size, input logic [1:0] offset);
    case (size)
      SIZE_B:  return 1'b0;
      SIZE_H:  return offset[0];          // Halfword must sit on an even byte
      default: return offset != 2'b00;
    endcase
  endfunction

endpackage

// File: lsu_align.sv
module lsu_align (
  input  logic [31:0]           addr,
  input  lsu_pkg::access_size_t size,
  input  logic                  sext,
  input  logic [31:0]           wsrc,
  input  logic [31:0]           rdata,
  output logic [31:0]           wdata,
  output logic [3:0]            wstrb,
  output logic [31:0]           load_value,
  output logic                  misaligned
);

  import lsu_pkg::*;

  logic [4:0]  shamt;
  logic [31:0] lane_word;
  logic        byte_sign;
  logic        half_sign;

  assign shamt = lane_shift(addr[1:0]);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Store side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Bits above the access size land outside the strobe and are ignored by the memory
  assign wdata = wsrc << shamt;
  assign wstrb = size_strobe(size) << addr[1:0];

  assign misaligned = is_misaligned(size, addr[1:0]);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Load side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign lane_word = rdata >> shamt;  // Selected lane now sits at bit 0

  assign byte_sign = sext & lane_word[7];
  assign half_sign = sext & lane_word[15];

  always_comb begin
    case (size)
      SIZE_B:  load_value = {{24{byte_sign}}, lane_word[7:0]};
      SIZE_H:  load_value = {{16{half_sign}}, lane_word[15:0]};
      default: load_value = lane_word;
    endcase
  end

endmodule

// File: lsu_fsm.sv
module lsu_fsm (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            ren,
  input  logic                            wen,
  input  logic [31:0]                     addr,
  input  logic                            misaligned,
  input  logic [31:0]                     load_value,
  output logic [31:0]                     rdata_q,
  output logic [31:0]                     mem_rdata,
  output logic                            read_done,
  output logic                            write_done,
  output logic                            access_error,
  output logic                            busy,
  output logic [axi_lite_pkg::ADDR_W-1:0] araddr,
  output logic                            arvalid,
  input  logic                            arready,
  input  logic [axi_lite_pkg::DATA_W-1:0] rdata,
  input  axi_lite_pkg::resp_t             rresp,
  input  logic                            rvalid,
  output logic                            rready,
  output logic [axi_lite_pkg::ADDR_W-1:0] awaddr,
  output logic                            awvalid,
  input  logic                            awready,
  output logic                            wvalid,
  input  logic                            wready,
  input  axi_lite_pkg::resp_t             bresp,
  input  logic                            bvalid,
  output logic                            bready
);

  import axi_lite_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_RADDR,
    S_RDATA,
    S_WADDR,
    S_WDATA,
    S_BRESP,
    S_DONE
  } state_t;

  state_t state;
  logic   is_write;  // Access kind as fixed at the request
  logic   err;       // Sticky error for the access in flight

  // Both channels carry the word address and the strobe picks the lanes
  assign araddr = {addr[31:2], 2'b00};
  assign awaddr = {addr[31:2], 2'b00};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Channel sequencing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= S_IDLE;
      is_write     <= 1'b0;
      err          <= 1'b0;
      busy         <= 1'b0;
      arvalid      <= 1'b0;
      rready       <= 1'b0;
      awvalid      <= 1'b0;
      wvalid       <= 1'b0;
      bready       <= 1'b0;
      read_done    <= 1'b0;
      write_done   <= 1'b0;
      access_error <= 1'b0;
    end else begin
      read_done    <= 1'b0;
      write_done   <= 1'b0;
      access_error <= 1'b0;
      case (state)
        S_IDLE: begin
          if (read_done || write_done) begin
            busy <= 1'b0;  // Done cycle still counts as busy
          end else if (!busy && (ren || wen)) begin
            busy     <= 1'b1;
            is_write <= wen;  // Write wins over a same-cycle read
            err      <= misaligned;
            if (misaligned) state <= S_DONE;
            else if (wen) begin
              awvalid <= 1'b1;
              state   <= S_WADDR;
            end else begin
              arvalid <= 1'b1;
              state   <= S_RADDR;
            end
          end
        end
        S_RADDR: if (arready) begin
          arvalid <= 1'b0;
          rready  <= 1'b1;
          state   <= S_RDATA;
        end
        S_RDATA: if (rvalid) begin
          rready  <= 1'b0;
          rdata_q <= rdata;
          err     <= (rresp != OKAY);
          state   <= S_DONE;
        end
        S_WADDR: if (awready) begin
          awvalid <= 1'b0;
          wvalid  <= 1'b1;
          state   <= S_WDATA;
        end
        S_WDATA: if (wready) begin
          wvalid <= 1'b0;
          bready <= 1'b1;
          state  <= S_BRESP;
        end
        S_BRESP: if (bvalid) begin
          bready <= 1'b0;
          err    <= (bresp != OKAY);
          state  <= S_DONE;
        end
        default: begin
          // rdata_q was captured last cycle, so load_value is settled here
          if (is_write) write_done <= 1'b1;
          else begin
            read_done <= 1'b1;
            mem_rdata <= err ? '0 : load_value;
          end
          access_error <= err;
          state        <= S_IDLE;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Protocol checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_one_addr_channel: assert property (@(posedge clock) disable iff (reset)
    !(arvalid && awvalid));

  a_arvalid_held: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid);

  a_single_done: assert property (@(posedge clock) disable iff (reset)
    !(read_done && write_done));

endmodule

// File: wait_timer.sv
module wait_timer #(
  parameter int WIDTH = 2
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             load,
  input  logic [WIDTH-1:0] count,
  output logic             done
);

  logic [WIDTH-1:0] remaining;

  always_ff @(posedge clock) begin
    if (reset) begin
      remaining <= '0;
    end else if (load) begin
      remaining <= count;
    end else if (remaining != '0) begin
      remaining <= remaining - 1'b1;
    end
  end

  // Stays high at zero until the next load
  assign done = (remaining == '0);

  // The slave only starts a new delay once the previous one has run out
  a_load_when_idle: assert property (@(posedge clock) disable iff (reset)
    load |-> remaining == '0);

endmodule

// File: axi_lite_sram.sv
module axi_lite_sram #(
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_CYCLES = 2
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic [axi_lite_pkg::ADDR_W-1:0] araddr,
  input  logic                            arvalid,
  output logic                            arready,
  output logic [axi_lite_pkg::DATA_W-1:0] rdata,
  output axi_lite_pkg::resp_t             rresp,
  output logic                            rvalid,
  input  logic                            rready,
  input  logic [axi_lite_pkg::ADDR_W-1:0] awaddr,
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [axi_lite_pkg::DATA_W-1:0] wdata,
  input  logic [axi_lite_pkg::STRB_W-1:0] wstrb,
  input  logic                            wvalid,
  output logic                            wready,
  output axi_lite_pkg::resp_t             bresp,
  output logic                            bvalid,
  input  logic                            bready
);

  import axi_lite_pkg::*;

  localparam int INDEX_W = $clog2(MEM_WORDS);
  localparam int TIMER_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WDATA,
    S_WAIT,
    S_RESP
  } state_t;

  state_t             state;
  logic               is_read;
  logic [DATA_W-1:0]  mem [MEM_WORDS];
  logic [ADDR_W-1:0]  aw_addr_q;
  logic [INDEX_W-1:0] ar_index;
  logic [INDEX_W-1:0] aw_index;
  logic               ar_in_range;
  logic               aw_in_range;
  logic               ar_fire;
  logic               aw_fire;
  logic               w_fire;
  logic               timer_load;
  logic               timer_done;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address decode and handshakes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // MEM_WORDS is a power of two, so any set bit above the index is out of range
  assign ar_index    = araddr[INDEX_W+1:2];
  assign aw_index    = aw_addr_q[INDEX_W+1:2];
  assign ar_in_range = (araddr[ADDR_W-1:INDEX_W+2] == '0);
  assign aw_in_range = (aw_addr_q[ADDR_W-1:INDEX_W+2] == '0);

  assign arready = (state == S_IDLE);
  assign awready = (state == S_IDLE) && !arvalid;  // Reads are taken first
  assign wready  = (state == S_WDATA);
  assign rvalid  = (state == S_RESP) && is_read;
  assign bvalid  = (state == S_RESP) && !is_read;

  assign ar_fire    = arvalid && arready;
  assign aw_fire    = awvalid && awready;
  assign w_fire     = wvalid && wready;
  assign timer_load = ar_fire || w_fire;

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= S_IDLE;
      is_read <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (ar_fire) begin
            is_read <= 1'b1;
            state   <= S_WAIT;
          end else if (aw_fire) begin
            is_read <= 1'b0;
            state   <= S_WDATA;
          end
        end
        S_WDATA: if (w_fire) state <= S_WAIT;
        S_WAIT:  if (timer_done) state <= S_RESP;
        default: if ((rvalid && rready) || (bvalid && bready)) state <= S_IDLE;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      rdata <= ar_in_range ? mem[ar_index] : '0;
      rresp <= ar_in_range ? OKAY : SLVERR;
    end
    if (aw_fire) aw_addr_q <= awaddr;
    if (w_fire) begin
      bresp <= aw_in_range ? OKAY : SLVERR;
      if (aw_in_range) begin
        for (int i = 0; i < STRB_W; i++) begin
          if (wstrb[i]) mem[aw_index][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  wait_timer #(
    .WIDTH (TIMER_W)
  ) u_wait_timer (
    .clock (clock),
    .reset (reset),
    .load  (timer_load),
    .count (TIMER_W'(WAIT_CYCLES)),
    .done  (timer_done)
  );

  // W is only presented by the master once its AW beat has gone through
  a_w_after_aw: assert property (@(posedge clock) disable iff (reset)
    wvalid |-> state == S_WDATA);

endmodule

// File: lsu_mem_top.sv
module lsu_mem_top #(
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_CYCLES = 2
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  ren,
  input  logic                  wen,
  input  lsu_pkg::access_size_t size,
  input  logic                  sext,
  input  logic [31:0]           addr,
  input  logic [31:0]           wsrc,
  output logic [31:0]           mem_rdata,
  output logic                  read_done,
  output logic                  write_done,
  output logic                  access_error,
  output logic                  busy
);

  import axi_lite_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Internal nets
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [31:0]       rdata_q;
  logic [31:0]       load_value;
  logic              misaligned;
  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [DATA_W-1:0] rdata;
  resp_t             rresp;
  logic              rvalid;
  logic              rready;
  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              wvalid;
  logic              wready;
  resp_t             bresp;
  logic              bvalid;
  logic              bready;

  lsu_align u_align (
    .addr       (addr),
    .size       (size),
    .sext       (sext),
    .wsrc       (wsrc),
    .rdata      (rdata_q),  // Registered word, not the bus
    .wdata      (wdata),
    .wstrb      (wstrb),
    .load_value (load_value),
    .misaligned (misaligned)
  );

  lsu_fsm u_fsm (
    .clock        (clock),
    .reset        (reset),
    .ren          (ren),
    .wen          (wen),
    .addr         (addr),
    .misaligned   (misaligned),
    .load_value   (load_value),
    .rdata_q      (rdata_q),
    .mem_rdata    (mem_rdata),
    .read_done    (read_done),
    .write_done   (write_done),
    .access_error (access_error),
    .busy         (busy),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rresp        (rresp),
    .rvalid       (rvalid),
    .rready       (rready),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wvalid       (wvalid),
    .wready       (wready),
    .bresp        (bresp),
    .bvalid       (bvalid),
    .bready       (bready)
  );

  axi_lite_sram #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_sram (
    .clock   (clock),
    .reset   (reset),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready)
  );

endmodule

// File: tb_clock.sv
module tb_clock (
  output logic clock,
  output logic reset
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD = 4;  // 8 ns clock
  localparam int RESET_CYCLES = 2;

  initial begin
    clock = 1'b0;
    forever #HALF_PERIOD clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

// File: lsu_mem_tb.sv
module lsu_mem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import lsu_pkg::*;

  localparam int MEM_WORDS   = 256;
  localparam int WAIT_CYCLES = 2;
  localparam int INDEX_W     = 8;
  localparam int MIN_LATENCY = WAIT_CYCLES + 4;
  localparam int TIMEOUT     = 200;

  logic         clock;
  logic         reset;
  logic         ren;
  logic         wen;
  access_size_t size;
  logic         sext;
  logic [31:0]  addr;
  logic [31:0]  wsrc;
  logic [31:0]  mem_rdata;
  logic         read_done;
  logic         write_done;
  logic         access_error;
  logic         busy;

  logic [31:0]  model [MEM_WORDS];  // Expected contents of the slave memory
  logic [31:0]  lcg_state;
  string        test_name;

  logic [31:0]  got_rdata;   // Outputs seen in the done cycle of the latest access
  logic         got_read_done;
  logic         got_write_done;
  logic         got_error;
  int           got_cycles;  // Edges from the request edge to the done pulse

  tb_clock u_clock (
    .clock (clock),
    .reset (reset)
  );

  lsu_mem_top #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) DUT (
    .clock        (clock),
    .reset        (reset),
    .ren          (ren),
    .wen          (wen),
    .size         (size),
    .sext         (sext),
    .addr         (addr),
    .wsrc         (wsrc),
    .mem_rdata    (mem_rdata),
    .read_done    (read_done),
    .write_done   (write_done),
    .access_error (access_error),
    .busy         (busy)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      stop_run($sformatf("Mismatch in %s, %s: expected %h, actual %h",
                         test_name, what, expected, actual));
    end
  endtask

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [INDEX_W-1:0] random_index();
    logic [31:0] r;
    r = next_random();
    return r[INDEX_W+15:16];  // Upper bits of an LCG are the better ones
  endfunction

  // Odd multiplier keeps every word of the fill distinct
  function automatic logic [31:0] fill_word(input logic [INDEX_W-1:0] idx);
    logic [31:0] wide;
    wide = 32'(idx);
    return (wide * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;
  endfunction

  function automatic logic [31:0] addr_of(input logic [INDEX_W-1:0] idx, input logic [1:0] off);
    return {{(30 - INDEX_W){1'b0}}, idx, off};
  endfunction

  function automatic logic [31:0] size_mask(input access_size_t sz);
    case (sz)
      SIZE_B:  return 32'h0000_00FF;
      SIZE_H:  return 32'h0000_FFFF;
      default: return 32'hFFFF_FFFF;
    endcase
  endfunction

  // A store replaces only the bytes it covers, starting at the byte offset
  function automatic void update_model(input logic [INDEX_W-1:0] idx, input access_size_t sz,
                                       input logic [1:0] off, input logic [31:0] data);
    logic [31:0] mask;
    logic [4:0]  shamt;
    mask  = size_mask(sz);
    shamt = {off, 3'b000};
    model[idx] = (model[idx] & ~(mask << shamt)) | ((data & mask) << shamt);
  endfunction

  function automatic logic [31:0] expected_load(input logic [31:0] word, input access_size_t sz,
                                                input logic sx, input logic [1:0] off);
    logic [31:0] lane;
    logic [4:0]  shamt;
    shamt = {off, 3'b000};
    lane  = (word >> shamt) & size_mask(sz);
    case (sz)
      SIZE_B:  if (sx && lane[7]) lane = lane | 32'hFFFF_FF00;
      SIZE_H:  if (sx && lane[15]) lane = lane | 32'hFFFF_0000;
      default: ;
    endcase
    return lane;
  endfunction

  // One request pulse, then wait for the done pulse and record the outputs
  task automatic access(input logic do_read, input logic do_write, input access_size_t sz,
                        input logic sx, input logic [31:0] a, input logic [31:0] data);
    int guard;
    guard = 0;
    @(posedge clock);
    while (reset || busy) begin
      guard++;
      if (guard > TIMEOUT) stop_run("Timed out waiting for the unit to become idle");
      @(posedge clock);
    end
    ren  <= do_read;
    wen  <= do_write;
    size <= sz;
    sext <= sx;
    addr <= a;
    wsrc <= data;
    @(posedge clock);  // The DUT takes the request on this edge
    ren <= 1'b0;
    wen <= 1'b0;
    got_cycles = 0;
    do begin
      @(posedge clock);
      got_cycles++;
      if (got_cycles > TIMEOUT) stop_run("Timed out waiting for a done pulse");
      check("busy during access", 32'd1, 32'(busy));
    end while (!(read_done || write_done));
    got_rdata      = mem_rdata;
    got_read_done  = read_done;
    got_write_done = write_done;
    got_error      = access_error;
    @(posedge clock);
    check("done pulse width", 32'd0, 32'(read_done || write_done));
    check("busy after done", 32'd0, 32'(busy));
  endtask

  task automatic store(input access_size_t sz, input logic [INDEX_W-1:0] idx,
                       input logic [1:0] off, input logic [31:0] data);
    access(1'b0, 1'b1, sz, 1'b0, addr_of(idx, off), data);
    check("write_done", 32'd1, 32'(got_write_done));
    check("access_error on write", 32'd0, 32'(got_error));
    update_model(idx, sz, off, data);
  endtask

  task automatic load_compare(input access_size_t sz, input logic sx,
                              input logic [INDEX_W-1:0] idx, input logic [1:0] off);
    access(1'b1, 1'b0, sz, sx, addr_of(idx, off), 32'd0);
    check("read_done", 32'd1, 32'(got_read_done));
    check("access_error on read", 32'd0, 32'(got_error));
    check("load value", expected_load(model[idx], sz, sx, off), got_rdata);
  endtask

  // Expects the access to end with its done pulse and access_error together
  task automatic failing_access(input logic is_read, input access_size_t sz,
                                input logic [31:0] a);
    access(is_read, !is_read, sz, 1'b0, a, next_random());
    if (is_read) begin
      check("read_done", 32'd1, 32'(got_read_done));
      check("rdata after error", 32'd0, got_rdata);
    end else begin
      check("write_done", 32'd1, 32'(got_write_done));
    end
    check("access_error", 32'd1, 32'(got_error));
  endtask

  task automatic verify_memory();
    logic [INDEX_W-1:0] idx;
    for (int i = 0; i < MEM_WORDS; i++) begin
      idx = i[INDEX_W-1:0];
      load_compare(SIZE_W, 1'b0, idx, 2'd0);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic preload_memory();
    logic [INDEX_W-1:0] idx;
    test_name = "preload";
    for (int i = 0; i < MEM_WORDS; i++) begin
      idx = i[INDEX_W-1:0];
      store(SIZE_W, idx, 2'd0, fill_word(idx));
    end
  endtask

  task automatic word_round_trip();
    logic [INDEX_W-1:0] written [$];
    logic [INDEX_W-1:0] idx;
    test_name = "word round trip";
    for (int n = 0; n < 16; n++) begin
      idx = random_index();
      written.push_back(idx);
      store(SIZE_W, idx, 2'd0, next_random());
      check("write latency", 32'd1, 32'(got_cycles >= MIN_LATENCY));
    end
    while (written.size() > 0) begin
      idx = written.pop_front();
      load_compare(SIZE_W, 1'b0, idx, 2'd0);
      check("read latency", 32'd1, 32'(got_cycles >= MIN_LATENCY));
    end
  endtask

  task automatic subword_merge();
    logic [INDEX_W-1:0] idx;
    test_name = "subword merge";
    idx = random_index();
    for (int off = 0; off < 4; off++) begin
      store(SIZE_W, idx, 2'd0, 32'h0123_4567);
      store(SIZE_B, idx, off[1:0], next_random());  // Upper wsrc bits must be dropped
      load_compare(SIZE_W, 1'b0, idx, 2'd0);
    end
    for (int off = 0; off < 4; off += 2) begin
      store(SIZE_W, idx, 2'd0, 32'h89AB_CDEF);
      store(SIZE_H, idx, off[1:0], next_random());
      load_compare(SIZE_W, 1'b0, idx, 2'd0);
    end
  endtask

  task automatic load_extension();
    logic [INDEX_W-1:0] idx;
    test_name = "load extension";
    for (int n = 0; n < 8; n++) begin
      idx = random_index();
      store(SIZE_W, idx, 2'd0, next_random());
      for (int off = 0; off < 4; off++) begin
        for (int s = 0; s < 2; s++) begin
          load_compare(SIZE_B, s[0], idx, off[1:0]);
          if (off[0] == 1'b0) load_compare(SIZE_H, s[0], idx, off[1:0]);
        end
      end
    end
  endtask

  task automatic out_of_range();
    test_name = "out of range";
    failing_access(1'b0, SIZE_W, 32'(MEM_WORDS * 4));  // First index past the end
    failing_access(1'b0, SIZE_B, 32'h8000_0013);
    failing_access(1'b1, SIZE_W, 32'(MEM_WORDS * 4));
    failing_access(1'b1, SIZE_H, 32'h0001_0002);
    verify_memory();  // Would catch a write that aliased onto a low word
  endtask

  task automatic misaligned_access();
    logic [INDEX_W-1:0] idx;
    access_size_t       sz;
    logic [1:0]         off;
    test_name = "misaligned access";
    for (int k = 0; k < 3; k++) begin
      idx = random_index();
      case (k)
        0: begin
          sz  = SIZE_H;
          off = 2'd1;
        end
        1: begin
          sz  = SIZE_H;
          off = 2'd3;
        end
        default: begin
          sz  = SIZE_W;
          off = 2'd2;
        end
      endcase
      failing_access(1'b0, sz, addr_of(idx, off));
      check("write done delay", 32'd2, got_cycles);
      failing_access(1'b1, sz, addr_of(idx, off));
      check("read done delay", 32'd2, got_cycles);
      load_compare(SIZE_W, 1'b0, idx, 2'd0);
    end
  endtask

  task automatic write_wins();
    logic [INDEX_W-1:0] idx;
    logic [31:0]        data;
    test_name = "write wins";
    idx  = random_index();
    data = next_random();
    access(1'b1, 1'b1, SIZE_W, 1'b0, addr_of(idx, 2'd0), data);
    check("write_done", 32'd1, 32'(got_write_done));
    check("read_done", 32'd0, 32'(got_read_done));
    check("access_error", 32'd0, 32'(got_error));
    update_model(idx, SIZE_W, 2'd0, data);
    load_compare(SIZE_W, 1'b0, idx, 2'd0);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    ren       = 1'b0;
    wen       = 1'b0;
    size      = SIZE_W;
    sext      = 1'b0;
    addr      = 32'd0;
    wsrc      = 32'd0;
    lcg_state = 32'd22593;
    test_name = "setup";
    preload_memory();
    word_round_trip();
    subword_merge();
    load_extension();
    out_of_range();
    misaligned_access();
    write_wins();
    $display("No errors");
    $finish;
  end

endmodule

// File: lsu_mem_top.f
axi_lite_pkg.sv
lsu_pkg.sv
lsu_align.sv
lsu_fsm.sv
wait_timer.sv
axi_lite_sram.sv
lsu_mem_top.sv
tb_clock.sv
lsu_mem_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module lsu_mem_tb \
		-f lsu_mem_top.f -o lsu_mem_sim
	./obj_dir/lsu_mem_sim

clean:
	rm -rf obj_dir
